//--- Makefile
# Verilator simulation of the ingress policer testbench

OBJ := obj_dir
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 -f all.f \
		--top-module ingress_policer_tb -Mdir $(OBJ)

# Pass only if the log holds the pass line
run: compile
	./$(OBJ)/Vingress_policer_tb | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- all.f
verilog/policer_pkg.sv
verilog/policer_config.sv
verilog/bucket_store.sv
verilog/bucket_arbiter.sv
verilog/leak_sweeper.sv
verilog/mark_engine.sv
verilog/ingress_policer.sv
bench/ingress_policer_asserts.sv
bench/ingress_policer_tb.sv

//--- bench/ingress_policer_asserts.sv
// Concurrent checks on the policer top level, bound in by the testbench
// Relies on the arbiter request and grant nets of the top level by name
`timescale 1ns/1ps

module ingress_policer_asserts (
    input logic                              core_clk_ifc,
    input logic                              timer_reset,
    input logic [policer_pkg::num_ports-1:0] enable,
    input logic                              pkt_valid,
    input policer_pkg::port_t                pkt_ingress_port,
    input policer_pkg::port_t                pkt_egress_port,
    input policer_pkg::prio_t                pkt_prio,
    input policer_pkg::blen_t                pkt_blen,
    input logic                              out_valid,
    input policer_pkg::port_t                out_ingress_port,
    input policer_pkg::port_t                out_egress_port,
    input policer_pkg::prio_t                out_prio,
    input policer_pkg::blen_t                out_blen,
    input logic                              out_drop_mark,
    input logic                              mark_req,
    input logic                              mark_gnt,
    input logic                              leak_req,
    input logic                              leak_gnt
);

    import policer_pkg::*;

    // Failure tally, read back by the testbench at the end
    int fail_count = 0;

    latency_a: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        out_valid == $past(pkt_valid))
        else begin
            $error("out_valid is not pkt_valid delayed by one cycle");
            fail_count++;
        end

    // Descriptor fields come out untouched
    fields_a: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        pkt_valid |=> (out_ingress_port == $past(pkt_ingress_port))
            && (out_egress_port == $past(pkt_egress_port))
            && (out_prio == $past(pkt_prio)) && (out_blen == $past(pkt_blen)))
        else begin
            $error("Output descriptor fields differ from the input descriptor");
            fail_count++;
        end

    reset_a: assert property (@(posedge core_clk_ifc) timer_reset |=> !out_valid)
        else begin
            $error("out_valid high while in reset");
            fail_count++;
        end

    grant_a: assert property (@(posedge core_clk_ifc)
        (!mark_gnt || mark_req) && (!leak_gnt || leak_req) && !(mark_gnt && leak_gnt))
        else begin
            $error("Bucket grant to a non-requester or to both engines");
            fail_count++;
        end

    disabled_a: assert property (@(posedge core_clk_ifc) disable iff (timer_reset)
        (pkt_valid && (pkt_ingress_port < num_ports) && !enable[pkt_ingress_port])
            |=> !out_drop_mark)
        else begin
            $error("Packet on a disabled port was marked");
            fail_count++;
        end

endmodule

//--- bench/ingress_policer_tb.sv
// Random and directed descriptor tests against a software token-bucket model
// The model has no leak, so random tests run with CIR 0 or far above any fill
`timescale 1ns/1ps

module ingress_policer_tb;

    import policer_pkg::*;

    localparam int period     = 40;
    localparam int rand_pkts  = 300;
    localparam int drain_cir  = 600;
    localparam int drain_cbs  = 1000;
    // Worst-case cycles per packet, set by the cir_drain waits
    localparam int pkt_gap    = 200;
    localparam int total_pkts = 4 * rand_pkts + 3 * num_ports;

    logic                  core_clk_ifc = 1'b0;
    logic                  timer_reset;
    logic                  cfg_wr;
    table_sel_t            cfg_sel;
    port_t                 cfg_port;
    logic [cfg_data_w-1:0] cfg_data;
    logic [num_ports-1:0]  enable;
    logic                  pkt_valid;
    port_t                 pkt_ingress_port;
    port_t                 pkt_egress_port;
    prio_t                 pkt_prio;
    blen_t                 pkt_blen;
    logic                  out_valid;
    port_t                 out_ingress_port;
    port_t                 out_egress_port;
    prio_t                 out_prio;
    blen_t                 out_blen;
    logic                  out_drop_mark;

    logic [31:0] rng_state = 32'h4fbf15ce;
    int          model_level [num_ports];
    int          model_cbs [num_ports];
    string       cur_test;
    int          test_errors;
    int          total_errors = 0;
    int          tests_done = 0;
    int          pkt_count = 0;
    int          drain_cycles;

    ingress_policer uut (.*);

    bind ingress_policer ingress_policer_asserts u_asserts (
        .core_clk_ifc, .timer_reset, .enable, .pkt_valid, .pkt_ingress_port,
        .pkt_egress_port, .pkt_prio, .pkt_blen, .out_valid, .out_ingress_port,
        .out_egress_port, .out_prio, .out_blen, .out_drop_mark,
        .mark_req, .mark_gnt, .leak_req, .leak_gnt
    );

    always #(period / 2) core_clk_ifc = ~core_clk_ifc;

    function automatic int unsigned next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return {8'h00, rng_state[31:8]};
    endfunction

    // Accumulate-or-mark on the whole-byte level
    function automatic logic expect_mark(input int port, input int blen);
        if (!enable[port]) begin
            return 1'b0;
        end
        if (model_level[port] + blen > model_cbs[port]) begin
            return 1'b1;
        end
        model_level[port] += blen;
        return 1'b0;
    endfunction

    task automatic cfg_write(input table_sel_t sel, input int port, input logic [31:0] data);
        cfg_wr   = 1'b1;
        cfg_sel  = sel;
        cfg_port = port_t'(port);
        cfg_data = data;
        @(negedge core_clk_ifc);
        cfg_wr   = 1'b0;
    endtask

    // Reset, then load every port; rand_cbs picks a CBS per port instead
    task automatic configure(input logic [31:0] cir, input logic [31:0] cbs, input logic rand_cbs);
        logic [31:0] burst;
        timer_reset = 1'b1;
        repeat (5) @(negedge core_clk_ifc);
        timer_reset = 1'b0;
        for (int p = 0; p < num_ports; p++) begin
            burst = rand_cbs ? (next_rand() % 20000) : cbs;
            cfg_write(sel_cir, p, cir);
            cfg_write(sel_cbs, p, burst);
            model_level[p] = 0;
            model_cbs[p]   = int'(burst[23:0]);
        end
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        $display("test %s done, %0d mismatches", cur_test, test_errors);
        total_errors += test_errors;
        tests_done++;
    endtask

    // Drive one descriptor, then check its mark one cycle later
    task automatic send_pkt(input int port, input int blen, input logic exp_mark);
        pkt_valid        = 1'b1;
        pkt_ingress_port = port_t'(port);
        pkt_egress_port  = port_t'(next_rand() % 16);
        pkt_prio         = prio_t'(next_rand() % 8);
        pkt_blen         = blen_t'(blen);
        @(negedge core_clk_ifc);
        pkt_valid = 1'b0;
        pkt_count++;
        if (!out_valid) begin
            $display("%s: no output one cycle after a descriptor on port %0d", cur_test, port);
            test_errors++;
        end else if (out_drop_mark !== exp_mark) begin
            $display("ERROR %s: expected mark %0b, actual %0b", cur_test, exp_mark, out_drop_mark);
            test_errors++;
        end
    endtask

    task automatic run_random(input int n);
        int port;
        int blen;
        for (int i = 0; i < n; i++) begin
            repeat (next_rand() % 3) @(negedge core_clk_ifc);
            port = int'(next_rand() % num_ports);
            blen = 64 + int'(next_rand() % 1437);
            send_pkt(port, blen, expect_mark(port, blen));
        end
    endtask

    initial begin
        timer_reset      = 1'b1;
        cfg_wr           = 1'b0;
        cfg_sel          = sel_cir;
        cfg_port         = '0;
        cfg_data         = '0;
        enable           = '1;
        // A descriptor during reset must not reach the output
        pkt_valid        = 1'b1;
        pkt_ingress_port = '0;
        pkt_egress_port  = '0;
        pkt_prio         = '0;
        pkt_blen         = '0;
        @(negedge core_clk_ifc);
        pkt_valid        = 1'b0;

        start_test("drop_all");
        configure(32'd0, 32'd0, 1'b0);
        run_random(rand_pkts);
        finish_test();

        start_test("accept_all");
        configure('1, '1, 1'b0);
        run_random(rand_pkts);
        finish_test();

        start_test("cbs_fill");
        configure(32'd0, 32'd0, 1'b1);
        run_random(rand_pkts);
        finish_test();

        ////////////////////////////////////////////////////////////////////////////
        // Leak timing, one port at a time

        start_test("cir_drain");
        configure(drain_cir, drain_cbs, 1'b0);
        drain_cycles = (drain_cbs * (1 << frac_bits) + drain_cir - 1) / drain_cir;
        for (int p = 0; p < num_ports; p++) begin
            send_pkt(p, drain_cbs, 1'b0);
            repeat (20) @(negedge core_clk_ifc);
            send_pkt(p, drain_cbs, 1'b1);
            repeat (drain_cycles + 3 * num_ports) @(negedge core_clk_ifc);
            send_pkt(p, drain_cbs, 1'b0);
        end
        finish_test();

        start_test("disable_mix");
        configure(32'd0, 32'd0, 1'b0);
        for (int c = 0; c < 6; c++) begin
            enable = num_ports'(next_rand());
            run_random(rand_pkts / 6);
        end
        finish_test();

        total_errors += uut.u_asserts.fail_count;
        $display("tests %0d, packets %0d, assertion failures %0d, total errors %0d",
                 tests_done, pkt_count, uut.u_asserts.fail_count, total_errors);
        if (total_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(longint'(total_pkts) * pkt_gap * 2 * period);
        $display("Watchdog expired before the tests finished");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- verilog/bucket_arbiter.sv
// Fixed-priority access to the bucket store, mark engine first
// Purely combinational; the losing engine's write is discarded
`timescale 1ns/1ps

module bucket_arbiter (
    // Mark engine side
    input  logic                mark_req,
    input  policer_pkg::port_t  mark_addr,
    input  logic                mark_wr,
    input  policer_pkg::level_t mark_wdata,
    output logic                mark_gnt,

    // Leak sweeper side
    input  logic                leak_req,
    input  policer_pkg::port_t  leak_addr,
    input  logic                leak_wr,
    input  policer_pkg::level_t leak_wdata,
    output logic                leak_gnt,

    // Store side
    output policer_pkg::port_t  store_addr,
    output logic                store_wr,
    output policer_pkg::level_t store_wdata
);

    ////////////////////////////////////////////////////////////////////////////
    // Grants

    // Packets never wait, so the sweeper only gets idle cycles
    assign mark_gnt = mark_req;
    assign leak_gnt = leak_req && !mark_req;

    ////////////////////////////////////////////////////////////////////////////
    // Steering

    always_comb begin
        if (mark_gnt) begin
            store_addr  = mark_addr;
            store_wr    = mark_wr;
            store_wdata = mark_wdata;
        end else begin
            store_addr  = leak_addr;
            store_wr    = leak_wr && leak_gnt;
            store_wdata = leak_wdata;
        end
    end

endmodule

//--- verilog/bucket_store.sv
// One bucket level per ingress port, single access port
// Read is combinational; an out-of-range address reads 0 and never writes
`timescale 1ns/1ps

module bucket_store (
    input  logic                core_clk_ifc,
    input  logic                timer_reset,
    input  policer_pkg::port_t  addr,
    input  logic                wr,
    input  policer_pkg::level_t wdata,
    output policer_pkg::level_t rdata
);

    import policer_pkg::*;

    level_t levels [num_ports];
    logic   addr_ok;

    assign addr_ok = (addr < num_ports);

    // Same-cycle read for the granted engine
    assign rdata = addr_ok ? levels[addr] : '0;

    ////////////////////////////////////////////////////////////////////////////
    // Level array

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < num_ports; i++) begin
                levels[i] <= '0;
            end
        end else if (wr && addr_ok) begin
            levels[addr] <= wdata;
        end
    end

endmodule

//--- verilog/ingress_policer.sv
// Ingress token-bucket policer, one bucket per port, no back-pressure
// Marked descriptor appears exactly one cycle after pkt_valid
`timescale 1ns/1ps

module ingress_policer (
    input  logic                               core_clk_ifc,
    input  logic                               timer_reset,
    input  logic                               cfg_wr,
    input  policer_pkg::table_sel_t            cfg_sel,
    input  policer_pkg::port_t                 cfg_port,
    input  logic [policer_pkg::cfg_data_w-1:0] cfg_data,
    input  logic [policer_pkg::num_ports-1:0]  enable,
    input  logic                               pkt_valid,
    input  policer_pkg::port_t                 pkt_ingress_port,
    input  policer_pkg::port_t                 pkt_egress_port,
    input  policer_pkg::prio_t                 pkt_prio,
    input  policer_pkg::blen_t                 pkt_blen,
    output logic                               out_valid,
    output policer_pkg::port_t                 out_ingress_port,
    output policer_pkg::port_t                 out_egress_port,
    output policer_pkg::prio_t                 out_prio,
    output policer_pkg::blen_t                 out_blen,
    output logic                               out_drop_mark
);

    import policer_pkg::*;

    rate_t  cir [num_ports];
    burst_t cbs [num_ports];

    logic   mark_req, mark_wr, mark_gnt;
    port_t  mark_addr;
    level_t mark_wdata;

    logic   leak_req, leak_wr, leak_gnt;
    port_t  leak_addr;
    level_t leak_wdata;

    port_t  store_addr;
    logic   store_wr;
    level_t store_wdata, store_rdata;

    policer_config u_config (
        .core_clk_ifc, .timer_reset, .cfg_wr, .cfg_sel, .cfg_port, .cfg_data,
        .cir, .cbs
    );

    bucket_store u_store (
        .core_clk_ifc, .timer_reset, .addr(store_addr), .wr(store_wr),
        .wdata(store_wdata), .rdata(store_rdata)
    );

    bucket_arbiter u_arbiter (
        .mark_req, .mark_addr, .mark_wr, .mark_wdata, .mark_gnt,
        .leak_req, .leak_addr, .leak_wr, .leak_wdata, .leak_gnt,
        .store_addr, .store_wr, .store_wdata
    );

    leak_sweeper u_sweeper (
        .core_clk_ifc, .timer_reset, .cir, .leak_req, .leak_addr, .leak_wr,
        .leak_wdata, .leak_gnt, .rdata(store_rdata)
    );

    mark_engine u_mark (
        .core_clk_ifc, .timer_reset, .enable, .cbs,
        .pkt_valid, .pkt_ingress_port, .pkt_egress_port, .pkt_prio, .pkt_blen,
        .mark_req, .mark_addr, .mark_wr, .mark_wdata, .rdata(store_rdata),
        .out_valid, .out_ingress_port, .out_egress_port, .out_prio, .out_blen,
        .out_drop_mark
    );

endmodule

//--- verilog/leak_sweeper.sv
// Round-robin drain of all buckets, one port per granted cycle
// Each visit removes num_ports times CIR, so the average rate is CIR per cycle
`timescale 1ns/1ps

module leak_sweeper (
    input  logic                core_clk_ifc,
    input  logic                timer_reset,
    input  policer_pkg::rate_t  cir [policer_pkg::num_ports],
    output logic                leak_req,
    output policer_pkg::port_t  leak_addr,
    output logic                leak_wr,
    output policer_pkg::level_t leak_wdata,
    input  logic                leak_gnt,
    input  policer_pkg::level_t rdata
);

    import policer_pkg::*;

    port_t              ptr;
    logic [drain_w-1:0] drain;
    logic [drain_w-1:0] level_ext;

    // Always asking; the arbiter decides
    assign leak_req  = 1'b1;
    assign leak_addr = ptr;
    assign leak_wr   = leak_gnt;

    ////////////////////////////////////////////////////////////////////////////
    // Saturated drain

    // Wide enough that an all-ones CIR cannot wrap
    assign drain     = drain_w'(cir[ptr]) * drain_w'(num_ports);
    assign level_ext = drain_w'(rdata);

    always_comb begin
        if (drain >= level_ext) begin
            leak_wdata = '0;
        end else begin
            leak_wdata = level_t'(level_ext - drain);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port pointer

    // Held while the mark engine owns the store
    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            ptr <= '0;
        end else if (leak_gnt) begin
            if (ptr == port_t'(num_ports - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= ptr + 1'b1;
            end
        end
    end

endmodule

//--- verilog/mark_engine.sv
// Per-packet bucket check and fill, one cycle from descriptor to marked output
// Ingress ports beyond the last one are treated as disabled
`timescale 1ns/1ps

module mark_engine (
    input  logic                              core_clk_ifc,
    input  logic                              timer_reset,
    input  logic [policer_pkg::num_ports-1:0] enable,
    input  policer_pkg::burst_t               cbs [policer_pkg::num_ports],
    input  logic                              pkt_valid,
    input  policer_pkg::port_t                pkt_ingress_port,
    input  policer_pkg::port_t                pkt_egress_port,
    input  policer_pkg::prio_t                pkt_prio,
    input  policer_pkg::blen_t                pkt_blen,
    output logic                              mark_req,
    output policer_pkg::port_t                mark_addr,
    output logic                              mark_wr,
    output policer_pkg::level_t               mark_wdata,
    input  policer_pkg::level_t               rdata,
    output logic                              out_valid,
    output policer_pkg::port_t                out_ingress_port,
    output policer_pkg::port_t                out_egress_port,
    output policer_pkg::prio_t                out_prio,
    output policer_pkg::blen_t                out_blen,
    output logic                              out_drop_mark
);

    import policer_pkg::*;

    logic               port_ok;
    logic               port_en;
    burst_t             port_cbs;
    logic [whole_w:0]   need;
    logic               over;
    logic               drop_mark;

    // Bucket access follows the descriptor strobe directly
    assign mark_req  = pkt_valid;
    assign mark_addr = pkt_ingress_port;

    ////////////////////////////////////////////////////////////////////////////
    // Decision

    assign port_ok  = (pkt_ingress_port < num_ports);
    assign port_en  = port_ok && enable[pkt_ingress_port];
    assign port_cbs = port_ok ? cbs[pkt_ingress_port] : '0;

    // Whole bytes of the current level plus this packet
    assign need = {1'b0, rdata[level_w-1:frac_bits]} + (whole_w + 1)'(pkt_blen);
    assign over = (need > (whole_w + 1)'(port_cbs));

    assign drop_mark = port_en && over;

    // Fill only on accept; cannot overflow since need stays within CBS
    assign mark_wr    = pkt_valid && port_en && !over;
    assign mark_wdata = rdata + (level_t'(pkt_blen) << frac_bits);

    ////////////////////////////////////////////////////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pkt_valid;
        end
    end

    always_ff @(posedge core_clk_ifc) begin
        if (pkt_valid) begin
            out_ingress_port <= pkt_ingress_port;
            out_egress_port  <= pkt_egress_port;
            out_prio         <= pkt_prio;
            out_blen         <= pkt_blen;
            out_drop_mark    <= drop_mark;
        end
    end

endmodule

//--- verilog/policer_config.sv
// CIR and CBS tables; writes to ports beyond the last one are dropped
// CBS keeps the low 24 bits of the written word
`timescale 1ns/1ps

module policer_config (
    input  logic                               core_clk_ifc,
    input  logic                               timer_reset,
    input  logic                               cfg_wr,
    input  policer_pkg::table_sel_t            cfg_sel,
    input  policer_pkg::port_t                 cfg_port,
    input  logic [policer_pkg::cfg_data_w-1:0] cfg_data,
    output policer_pkg::rate_t                 cir [policer_pkg::num_ports],
    output policer_pkg::burst_t                cbs [policer_pkg::num_ports]
);

    import policer_pkg::*;

    logic port_ok;
    logic cir_we;
    logic cbs_we;

    // Write decode by table select and port range
    assign port_ok = (cfg_port < num_ports);
    assign cir_we  = cfg_wr && port_ok && (cfg_sel == sel_cir);
    assign cbs_we  = cfg_wr && port_ok && (cfg_sel == sel_cbs);

    ////////////////////////////////////////////////////////////////////////////
    // Rate table

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < num_ports; i++) begin
                cir[i] <= '0;
            end
        end else if (cir_we) begin
            cir[cfg_port] <= rate_t'(cfg_data);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Burst table

    always_ff @(posedge core_clk_ifc) begin
        if (timer_reset) begin
            for (int i = 0; i < num_ports; i++) begin
                cbs[i] <= '0;
            end
        end else if (cbs_we) begin
            // Upper byte of the word is discarded
            cbs[cfg_port] <= cfg_data[burst_w-1:0];
        end
    end

endmodule

//--- verilog/policer_pkg.sv
// Shared widths and encodings for the ingress policer
// Bucket and rate values carry 8 fraction bits; CBS is whole bytes only

package policer_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Port numbering

    localparam int num_ports = 11;
    localparam int port_w    = 4;

    typedef logic [port_w-1:0] port_t;

    ////////////////////////////////////////////////////////////////////////////
    // Descriptor fields

    localparam int prio_w = 3;
    localparam int blen_w = 11;

    typedef logic [prio_w-1:0] prio_t;

    // Supported lengths 64 to 1500 bytes
    typedef logic [blen_w-1:0] blen_t;

    ////////////////////////////////////////////////////////////////////////////
    // Fixed-point bucket format

    localparam int frac_bits = 8;
    localparam int rate_w    = 32;
    localparam int level_w   = 32;
    localparam int burst_w   = 24;
    localparam int whole_w   = level_w - frac_bits;

    // Room for num_ports times a full-scale CIR
    localparam int drain_w   = rate_w + port_w;

    typedef logic [rate_w-1:0]  rate_t;
    typedef logic [level_w-1:0] level_t;
    typedef logic [burst_w-1:0] burst_t;

    ////////////////////////////////////////////////////////////////////////////
    // Configuration

    localparam int cfg_data_w = 32;

    typedef logic table_sel_t;

    localparam table_sel_t sel_cir = 1'b0;
    localparam table_sel_t sel_cbs = 1'b1;

endpackage
